//--- flist.f
+incdir+rtl
rtl/router_pkg.sv
rtl/xbar_if.sv
rtl/msg_queue.sv
rtl/input_port.sv
rtl/output_port.sv
rtl/ring_router.sv
tb/tb_clkgen.sv
tb/tb_ring_router.sv

//--- run.sh
#!/usr/bin/env bash
# build the ring router testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f flist.f \
  --top-module tb_ring_router \
  --Mdir obj_dir \
  -o sim_ring_router

# a failing run exits non-zero, the grep below decides the result
sim_out=$(./obj_dir/sim_ring_router 2>&1 || true)
echo "$sim_out"

if grep -q "TEST OK" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

//--- tb/tb_ring_router.sv
// directed testbench for one ring router with id 3
// inputs change 1 ns after the rising edge, deliveries are logged at the edge

`timescale 1ns/1ns

module tb_ring_router;
  import router_pkg::*;

  localparam int ROUTER_ID = 3;
  // the tests take well under 200 cycles and the limit leaves wide margin
  localparam int CYCLE_LIMIT = 2000;
  localparam int WAIT_LIMIT  = 50;

  typedef struct packed {
    logic [1:0]  port;
    logic [31:0] cyc;
    net_msg_t    msg;
  } seen_t;

  logic        clk;
  logic        reset;
  logic [2:0]  in_val;
  logic [2:0]  in_rdy;
  net_msg_t    in_msg [3];
  logic [2:0]  out_val;
  logic [2:0]  out_rdy;
  net_msg_t    out_msg [3];
  logic [31:0] cycle = '0;
  logic [31:0] last_accept;
  logic [31:0] lfsr_state;
  int          msg_count = 0;
  seen_t       seen_q [$];

  tb_clkgen clkgen_i (.clk(clk), .reset(reset));

  ring_router #(.router_id(ROUTER_ID)) dut_i (
    .clk(clk), .reset(reset),
    .in0_val(in_val[0]), .in0_rdy(in_rdy[0]), .in0_msg(in_msg[0]),
    .in1_val(in_val[1]), .in1_rdy(in_rdy[1]), .in1_msg(in_msg[1]),
    .in2_val(in_val[2]), .in2_rdy(in_rdy[2]), .in2_msg(in_msg[2]),
    .out0_val(out_val[0]), .out0_rdy(out_rdy[0]), .out0_msg(out_msg[0]),
    .out1_val(out_val[1]), .out1_rdy(out_rdy[1]), .out1_msg(out_msg[1]),
    .out2_val(out_val[2]), .out2_rdy(out_rdy[2]), .out2_msg(out_msg[2])
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic fail_now(input string why);
    $display("%s at t=%0t", why, $time);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got %0h exp %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] next_payload();
    logic [31:0] p;
    p = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      p = {p[30:0], lfsr_state[0]};
    end
    return p;
  endfunction

  function automatic net_msg_t make_msg(input int dest, input int src);
    net_msg_t m;
    m.dest    = dest[2:0];
    m.src     = src[2:0];
    m.opaque  = msg_count[2:0];
    m.payload = next_payload();
    msg_count++;
    return m;
  endfunction

  // expected output port from the routing rules
  function automatic int expected_port(input int in_port, input int dest);
    int fwd;
    if (dest == ROUTER_ID) begin
      return 1;
    end
    if (in_port == 0) begin
      return 2;
    end
    if (in_port == 2) begin
      return 0;
    end
    fwd = (dest - ROUTER_ID + 8) % 8;
    return (fwd <= 4) ? 2 : 0;
  endfunction

  task automatic send_msg(input int p, input net_msg_t m);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    in_val[p] = 1'b1;
    in_msg[p] = m;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        fail_now($sformatf("input %0d never accepted a message", p));
      end
    end while (!in_rdy[p]);
    last_accept = cycle;
    #1;
    in_val[p] = 1'b0;
  endtask

  task automatic expect_delivery(input int in_port, input net_msg_t m, input bit check_lat);
    seen_t r;
    int    n;
    n = 0;
    while (seen_q.size() == 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        fail_now("no message reached any output");
      end
    end
    r = seen_q.pop_front();
    check_val("output port", r.port, expected_port(in_port, m.dest));
    check_val($sformatf("out%0d_msg", r.port), r.msg, m);
    if (check_lat) begin
      check_val("latency", r.cyc - last_accept, 1);
    end
  endtask

  // transfers are logged with the cycle of the edge they happen on
  always @(posedge clk) begin
    if (!reset) begin
      for (int j = 0; j < 3; j++) begin
        if (out_val[j] && out_rdy[j]) begin
          seen_q.push_back(seen_t'{port: j[1:0], cyc: cycle, msg: out_msg[j]});
        end
      end
    end
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout, run passed %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic reset_state();
    check_val("out_val", out_val, 3'b000);
    check_val("in_rdy", in_rdy, 3'b111);
  endtask

  task automatic ring_routes();
    int       ports [4] = '{0, 0, 2, 2};
    int       dests [4] = '{5, 3, 1, 3};
    net_msg_t m;
    for (int i = 0; i < 4; i++) begin
      m = make_msg(dests[i], ports[i] == 0 ? 2 : 4);
      send_msg(ports[i], m);
      expect_delivery(ports[i], m, 1'b1);
    end
  endtask

  task automatic terminal_routes();
    net_msg_t m;
    for (int d = 0; d < 8; d++) begin
      if (d != ROUTER_ID) begin
        m = make_msg(d, ROUTER_ID);
        send_msg(1, m);
        expect_delivery(1, m, 1'b1);
      end
    end
  endtask

  // out1 last served input 2 in the ring test, so its pointer is back at input 0
  task automatic round_robin_order();
    net_msg_t m [3];
    for (int round = 0; round < 2; round++) begin
      @(posedge clk);
      #1;
      out_rdy[1] = 1'b0;
      for (int p = 0; p < 3; p++) begin
        m[p] = make_msg(ROUTER_ID, p + 1);
        send_msg(p, m[p]);
      end
      repeat (2) @(negedge clk);
      check_val("deliveries while out1 stalled", seen_q.size(), 0);
      @(posedge clk);
      #1;
      out_rdy[1] = 1'b1;
      for (int p = 0; p < 3; p++) begin
        expect_delivery(p, m[p], 1'b0);
      end
    end
    // a lone in0 delivery moves the pointer to input 1, then in2 wins over in0
    m[0] = make_msg(ROUTER_ID, 2);
    send_msg(0, m[0]);
    expect_delivery(0, m[0], 1'b1);
    @(posedge clk);
    #1;
    out_rdy[1] = 1'b0;
    m[0] = make_msg(ROUTER_ID, 2);
    m[2] = make_msg(ROUTER_ID, 4);
    send_msg(0, m[0]);
    send_msg(2, m[2]);
    repeat (2) @(negedge clk);
    check_val("deliveries while out1 stalled", seen_q.size(), 0);
    @(posedge clk);
    #1;
    out_rdy[1] = 1'b1;
    expect_delivery(2, m[2], 1'b0);
    expect_delivery(0, m[0], 1'b0);
  endtask

  task automatic back_pressure();
    net_msg_t m [10];
    net_msg_t held;
    for (int i = 0; i < 10; i++) begin
      m[i] = make_msg(6, 2);
    end
    @(posedge clk);
    #1;
    out_rdy[2] = 1'b0;
    send_msg(0, m[0]);
    send_msg(0, m[1]);
    @(negedge clk);
    check_val("in0_rdy", in_rdy[0], 1'b0);
    held = out_msg[2];
    check_val("out2_msg", held, m[0]);
    repeat (4) begin
      @(negedge clk);
      check_val("out2_val", out_val[2], 1'b1);
      check_val("out2_msg", out_msg[2], held);
      check_val("in0_rdy", in_rdy[0], 1'b0);
    end
    check_val("deliveries while out2 stalled", seen_q.size(), 0);
    @(posedge clk);
    #1;
    out_rdy[2] = 1'b1;
    fork
      begin
        for (int i = 2; i < 10; i++) begin
          send_msg(0, m[i]);
        end
      end
      begin
        for (int i = 0; i < 10; i++) begin
          expect_delivery(0, m[i], 1'b0);
        end
      end
    join
    repeat (3) @(negedge clk);
    check_val("extra deliveries", seen_q.size(), 0);
  endtask

  initial begin
    in_val     = '0;
    out_rdy    = '1;
    lfsr_state = 32'h7c6d;
    for (int i = 0; i < 3; i++) begin
      in_msg[i] = '0;
    end
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    reset_state();
    ring_routes();
    terminal_routes();
    round_robin_order();
    back_pressure();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- tb/tb_clkgen.sv
// clock and reset source for the router testbench
// 10 ns clock, reset held high over the first three rising edges

`timescale 1ns/1ns

module tb_clkgen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- rtl/ring_router.sv
// three-port ring router: previous router, local terminal, next router
// each port pair uses a valid/ready handshake

`timescale 1ns/1ns

module ring_router #(
  parameter int router_id = 0
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 in0_val,
  output logic                 in0_rdy,
  input  router_pkg::net_msg_t in0_msg,

  input  logic                 in1_val,
  output logic                 in1_rdy,
  input  router_pkg::net_msg_t in1_msg,

  input  logic                 in2_val,
  output logic                 in2_rdy,
  input  router_pkg::net_msg_t in2_msg,

  output logic                 out0_val,
  input  logic                 out0_rdy,
  output router_pkg::net_msg_t out0_msg,

  output logic                 out1_val,
  input  logic                 out1_rdy,
  output router_pkg::net_msg_t out1_msg,

  output logic                 out2_val,
  input  logic                 out2_rdy,
  output router_pkg::net_msg_t out2_msg
);
  import router_pkg::*;

  xbar_if xb ();

  // ----------------------------------------
  // input ports
  // ----------------------------------------

  input_port #(.port_id(PORT_PREV), .router_id(router_id)) in0_port (
    .clk    (clk),
    .reset  (reset),
    .in_val (in0_val),
    .in_rdy (in0_rdy),
    .in_msg (in0_msg),
    .xb     (xb.in_side)
  );

  input_port #(.port_id(PORT_TERM), .router_id(router_id)) in1_port (
    .clk    (clk),
    .reset  (reset),
    .in_val (in1_val),
    .in_rdy (in1_rdy),
    .in_msg (in1_msg),
    .xb     (xb.in_side)
  );

  input_port #(.port_id(PORT_NEXT), .router_id(router_id)) in2_port (
    .clk    (clk),
    .reset  (reset),
    .in_val (in2_val),
    .in_rdy (in2_rdy),
    .in_msg (in2_msg),
    .xb     (xb.in_side)
  );

  // ----------------------------------------
  // output ports
  // ----------------------------------------

  output_port #(.port_id(PORT_PREV)) out0_port (
    .clk     (clk),
    .reset   (reset),
    .out_val (out0_val),
    .out_rdy (out0_rdy),
    .out_msg (out0_msg),
    .xb      (xb.out_side)
  );

  output_port #(.port_id(PORT_TERM)) out1_port (
    .clk     (clk),
    .reset   (reset),
    .out_val (out1_val),
    .out_rdy (out1_rdy),
    .out_msg (out1_msg),
    .xb      (xb.out_side)
  );

  output_port #(.port_id(PORT_NEXT)) out2_port (
    .clk     (clk),
    .reset   (reset),
    .out_val (out2_val),
    .out_rdy (out2_rdy),
    .out_msg (out2_msg),
    .xb      (xb.out_side)
  );

endmodule

//--- rtl/output_port.sv
// one router output: round-robin arbiter and message select
// grants go out only while the downstream side is ready

`timescale 1ns/1ns
`include "router_defs.svh"

module output_port #(
  parameter int port_id = 0
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic                 out_val,
  input  logic                 out_rdy,
  output router_pkg::net_msg_t out_msg,
  xbar_if.out_side             xb
);
  import router_pkg::*;

  localparam int num_ports = `NET_NUM_PORTS;
  localparam int idx_nbits = $clog2(num_ports);

  port_vec_t            reqs;
  port_vec_t            grants;
  logic [idx_nbits-1:0] pri_ptr;
  logic [idx_nbits-1:0] sel;
  logic [idx_nbits-1:0] sel_next;
  logic                 found;

  // column of requests aimed at this output
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      reqs[i] = xb.req[i][port_id];
    end
  end

  // ----------------------------------------
  // arbiter
  // ----------------------------------------

  // first requester at or after the priority pointer
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = pri_ptr;
    for (int k = 0; k < num_ports; k++) begin
      idx = int'(pri_ptr) + k;
      if (idx >= num_ports) begin
        idx = idx - num_ports;
      end
      if (!found && reqs[idx]) begin
        found = 1'b1;
        sel   = idx[idx_nbits-1:0];
      end
    end
  end

  assign sel_next = (sel == idx_nbits'(num_ports - 1)) ? '0 : sel + 1'b1;

  always_comb begin
    grants = '0;
    if (out_rdy && found) begin
      grants[sel] = 1'b1;
    end
  end

  assign xb.grant[port_id] = grants;

  // pointer moves past the winner on the transfer edge
  always_ff @(posedge clk) begin
    if (reset) begin
      pri_ptr <= '0;
    end else if (out_rdy && found) begin
      pri_ptr <= sel_next;
    end
  end

  // ----------------------------------------
  // message select
  // ----------------------------------------

  assign out_val = found;
  assign out_msg = xb.msg[sel];

endmodule

//--- rtl/input_port.sv
// one router input: message queue plus route computation
// the queue head raises exactly one request bit toward its output

`timescale 1ns/1ns
`include "router_defs.svh"

module input_port #(
  parameter int port_id   = 0,
  parameter int router_id = 0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  router_pkg::net_msg_t in_msg,
  xbar_if.in_side              xb
);
  import router_pkg::*;

  localparam int sd_nbits = `NET_SRCDEST_NBITS;
  localparam logic [sd_nbits:0] own_id    = (sd_nbits + 1)'(router_id);
  localparam logic [sd_nbits:0] ring_size = (sd_nbits + 1)'(`NET_NUM_ROUTERS);

  logic              head_val;
  logic              head_rdy;
  net_msg_t          head_msg;
  logic [sd_nbits:0] fwd_sum;
  logic [sd_nbits:0] fwd_dist;
  port_vec_t         route;
  port_vec_t         grants;

  msg_queue queue_i (
    .clk     (clk),
    .reset   (reset),
    .enq_val (in_val),
    .enq_rdy (in_rdy),
    .enq_msg (in_msg),
    .deq_val (head_val),
    .deq_rdy (head_rdy),
    .deq_msg (head_msg)
  );

  // forward distance, (dest - id) mod ring size
  assign fwd_sum  = {1'b0, head_msg.dest} + (ring_size - own_id);
  assign fwd_dist = (fwd_sum >= ring_size) ? fwd_sum - ring_size : fwd_sum;

  always_comb begin
    route = '0;
    if (head_val) begin
      if ({1'b0, head_msg.dest} == own_id) begin
        route[PORT_TERM] = 1'b1;
      end else if (port_id == PORT_PREV) begin
        route[PORT_NEXT] = 1'b1;
      end else if (port_id == PORT_NEXT) begin
        route[PORT_PREV] = 1'b1;
      end else if (fwd_dist <= (ring_size >> 1)) begin
        // terminal traffic, a tie at half the ring goes forward
        route[PORT_NEXT] = 1'b1;
      end else begin
        route[PORT_PREV] = 1'b1;
      end
    end
  end

  // grant bit for this input from every output
  always_comb begin
    for (int j = 0; j < `NET_NUM_PORTS; j++) begin
      grants[j] = xb.grant[j][port_id];
    end
  end

  assign head_rdy        = |grants;
  assign xb.req[port_id] = route;
  assign xb.msg[port_id] = head_msg;

endmodule

//--- rtl/msg_queue.sv
// two-entry valid/ready FIFO for network messages
// dequeue side reads storage only, so there is no bypass path

`timescale 1ns/1ns
`include "router_defs.svh"

module msg_queue (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enq_val,
  output logic                 enq_rdy,
  input  router_pkg::net_msg_t enq_msg,
  output logic                 deq_val,
  input  logic                 deq_rdy,
  output router_pkg::net_msg_t deq_msg
);
  import router_pkg::*;

  localparam int depth     = `NET_QUEUE_DEPTH;
  localparam int ptr_nbits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_nbits = $clog2(depth + 1);

  net_msg_t             mem [depth];
  logic [ptr_nbits-1:0] wr_ptr;
  logic [ptr_nbits-1:0] rd_ptr;
  logic [cnt_nbits-1:0] count;
  logic                 do_enq;
  logic                 do_deq;

  function automatic logic [ptr_nbits-1:0] next_ptr(input logic [ptr_nbits-1:0] p);
    if (p == ptr_nbits'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign enq_rdy = (count < cnt_nbits'(depth));
  assign deq_val = (count != '0);
  assign deq_msg = mem[rd_ptr];

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // count only moves when exactly one side fires
      if (do_enq && !do_deq) begin
        count <= count + 1'b1;
      end else if (do_deq && !do_enq) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/xbar_if.sv
// request, grant and message lines between input and output ports
// one instance per router

`timescale 1ns/1ns
`include "router_defs.svh"

interface xbar_if;
  import router_pkg::*;

  // req and msg indexed by input, grant indexed by output
  port_vec_t req   [`NET_NUM_PORTS];
  port_vec_t grant [`NET_NUM_PORTS];
  net_msg_t  msg   [`NET_NUM_PORTS];

  modport in_side (
    output req,
    output msg,
    input  grant
  );

  modport out_side (
    input  req,
    input  msg,
    output grant
  );

endinterface

//--- rtl/router_pkg.sv
// shared types for the ring router and its testbench
// compile before any file that imports it

`include "router_defs.svh"

package router_pkg;

  // network message, dest sits in the top bits
  typedef struct packed {
    logic [`NET_SRCDEST_NBITS-1:0] dest;
    logic [`NET_SRCDEST_NBITS-1:0] src;
    logic [`NET_OPAQUE_NBITS-1:0]  opaque;
    logic [`NET_PAYLOAD_NBITS-1:0] payload;
  } net_msg_t;

  // one bit per router port, used for requests and grants
  typedef logic [`NET_NUM_PORTS-1:0] port_vec_t;

  // port 0 faces the previous router, port 2 the next one
  localparam int PORT_PREV = 0;
  localparam int PORT_TERM = 1;
  localparam int PORT_NEXT = 2;

endpackage

//--- rtl/router_defs.svh
// field widths and sizing constants for the ring router
// included by the package and by modules that size logic from them

`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// message fields
`define NET_PAYLOAD_NBITS 32
`define NET_OPAQUE_NBITS 3
`define NET_SRCDEST_NBITS 3

// network shape
`define NET_NUM_ROUTERS 8
`define NET_QUEUE_DEPTH 2
`define NET_NUM_PORTS 3

`endif
